//--- verilog.f
cmprs_pkg.sv
cmprs_tile_buf.sv
cmprs_pixel_buf_iface.sv
cmprs_mb_sequencer.sv
cmprs_pixel_top.sv
tb_cmprs_pixel.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
    --top-module tb_cmprs_pixel -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q "TB FAILED" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
echo "simulation passed"

//--- tb_cmprs_pixel.sv
// fixed case table, two back-to-back commands per case; DUT built with one extra buffer stage
module tb_cmprs_pixel;
    import cmprs_pkg::*;

    localparam int buf_lat       = 1;     // one extra register layer in the buffer read path
    localparam int preend_early  = 6;
    localparam int release_early = 16;
    localparam int wait_limit    = 3000;  // cycles, longer than any macroblock period

    logic xclk, arst_n, frame_en, mb_req, mb_ack, wr_en, tile_col_width;
    logic data_valid, pre_first_out, mb_release_buf, mb_pre_end;
    logic [1:0] start_page, tile_width, cmd_page;
    logic [6:0] macroblock_x, cmd_x;
    logic [5:0] mb_w_m1, mb_h_m1;
    logic [11:0] wr_addr;
    logic [7:0] wr_data, data_out;
    cmprs_mode_e converter_type;
    logic [7:0] mirror [0:4095];             // copy of everything written to the buffer
    logic [7:0] byte_q[$];                   // expected bytes
    int cyc_q[$];                            // cycle of each expected byte
    bit first_q[$];                          // first byte of a macroblock
    int pe_q[$];                             // expected mb_pre_end cycles
    int rel_q[$];                            // expected mb_release_buf cycles
    int cyc, err_cnt, byte_cnt, pulse_cnt, cur_period;
    int unsigned seed_val;
    bit quiet, early_req, prev_ack, prev_req, prev_pe, prev_pfo;

    // mode, w_m1, h_m1, tile_width, col_width, start_page, mb_x, period
    int case_tbl [6][8] = '{
        '{0, 15, 15, 0, 0, 3,   8, 384},     // 16 wide tiles, page 3 wraps to 0
        '{1, 19, 17, 1, 1, 1,  20, 400},     // 32 wide tile and column, tile border at 32
        '{2, 15, 15, 2, 0, 2,  56, 384},     // last column of a 64 tile, then next page
        '{3, 15,  7, 3, 1, 0,  24, 256},     // 128 tile, column border inside the page
        '{4, 15, 14, 2, 1, 1, 120, 256},     // skips one tile, crosses into a third
        '{7,  7,  6, 0, 0, 2,  76,  64}      // short period, x past 64 wraps the pages
    };

    assign mb_pre_end = UUT.mb_pre_end;      // internal pacing pulse, not a top port

    cmprs_pixel_top #(
        .preend_early      (preend_early),
        .release_early     (release_early),
        .buf_extra_latency (buf_lat)
    ) UUT (.*);

    always #2 xclk = ~xclk;

    // buffer address of pixel (r, c) by the tile / column layout
    function automatic logic [11:0] pixel_addr(input int page, input int x0, input int r,
                                               input int c);
        int tw, cw, h, x, off;
        tw  = 16 << tile_width;
        cw  = tile_col_width ? 32 : 16;
        h   = int'(mb_h_m1) + 1;
        x   = x0 + c;
        off = ((x % tw) / cw) * cw * h + r * cw + x % cw; // column block, row, pixel
        return {2'((page + x / tw) % 4), 10'(off)};
    endfunction

    task automatic step(input int n);
        repeat (n) begin
            @(posedge xclk);
            #1;                                  // drive after the edge
        end
    endtask

    task automatic finish_run;
        $display("bytes %0d pulses %0d errors %0d", byte_cnt, pulse_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    endtask

    task automatic abort_on_timeout(input string what);
        err_cnt++;
        $display("timeout at t=%0t while waiting for %s", $time, what);
        finish_run();
    endtask

    task automatic fill_buffer;
        logic [7:0] d;
        for (int a = 0; a < 4096; a++) begin
            d          = 8'($urandom);
            mirror[a]  = d;
            wr_en      = 1'b1;
            wr_addr    = 12'(a);
            wr_data    = d;
            step(1);
        end
        wr_en = 1'b0;
    endtask

    task automatic apply_config(input int i);
        converter_type = cmprs_mode_e'(case_tbl[i][0]);
        mb_w_m1        = 6'(case_tbl[i][1]);
        mb_h_m1        = 6'(case_tbl[i][2]);
        tile_width     = 2'(case_tbl[i][3]);
        tile_col_width = 1'(case_tbl[i][4]);
        cur_period     = case_tbl[i][7];
        step(1);
    endtask

    // one four-phase handshake; early means the DUT still runs the previous macroblock
    task automatic send_cmd(input logic [1:0] page, input logic [6:0] x, input bit early);
        int n;
        cmd_page     = page;
        cmd_x        = x;
        early_req    = early;
        start_page   = page;
        macroblock_x = x;
        mb_req       = 1'b1;
        n = 0;
        while (!mb_ack) begin
            step(1);
            n++;
            if (n > wait_limit) abort_on_timeout("mb_ack to rise");
        end
        assert (early || n == 1) else begin
            err_cnt++;
            $display("Fail t=%0t mb_ack latency exp 1 got %0d", $time, n);
        end
        step(2);                                 // req stays up a while, ack must hold
        mb_req = 1'b0;
        n = 0;
        while (mb_ack) begin
            step(1);
            n++;
            if (n > wait_limit) abort_on_timeout("mb_ack to fall");
        end
    endtask

    task automatic wait_drain;
        int n;
        n = 0;
        while (byte_q.size() != 0 || pe_q.size() != 0 || rel_q.size() != 0) begin
            step(1);
            n++;
            if (n > wait_limit) abort_on_timeout("macroblock bytes and pacing pulses");
        end
    endtask

    // scoreboard, sampled at the falling edge where outputs are settled
    always @(negedge xclk) begin : monitor
        int n;
        bit hit, exp_first;
        cyc++;
        if (arst_n && quiet) begin
            assert (!data_valid && !pre_first_out && !mb_pre_end && !mb_release_buf) else begin
                err_cnt++;
                $display("t=%0t output pulse seen after frame_en was dropped", $time);
            end
        end else if (arst_n) begin
            if (mb_ack && !prev_ack) begin       // mb_pre_start follows next cycle
                assert (prev_req && pe_q.size() == 0) else begin
                    err_cnt++;
                    $display("t=%0t mb_ack rose without mb_req or before mb_pre_end", $time);
                end
                assert (!early_req || prev_pe) else begin
                    err_cnt++;
                    $display("t=%0t queued request not acked right after mb_pre_end", $time);
                end
                n = 0;
                for (int r = 0; r <= int'(mb_h_m1); r++) begin
                    for (int c = 0; c <= int'(mb_w_m1); c++) begin
                        byte_q.push_back(mirror[pixel_addr(cmd_page, cmd_x, r, c)]);
                        cyc_q.push_back(cyc + buf_lat + 5 + n); // start, address, 3+lat stages
                        first_q.push_back(n == 0);
                        n++;
                    end
                end
                pe_q.push_back(cyc + cur_period - preend_early);
                rel_q.push_back(cyc + cur_period - release_early);
            end
            assert (mb_ack || !prev_ack || !prev_req) else begin
                err_cnt++;
                $display("t=%0t mb_ack dropped while mb_req was still high", $time);
            end
            hit = 1'b0;
            if (cyc_q.size() > 0) hit = (cyc_q[0] == cyc);
            exp_first = hit ? first_q[0] : 1'b0;
            assert (prev_pfo == exp_first) else begin
                err_cnt++;
                $display("Fail t=%0t pre_first_out exp %0b got %0b", $time, exp_first, prev_pfo);
            end
            assert (data_valid == hit) else begin
                err_cnt++;
                $display("Fail t=%0t data_valid exp %0b got %0b", $time, hit, data_valid);
            end
            if (hit) begin
                assert (!data_valid || data_out == byte_q[0]) else begin
                    err_cnt++;
                    $display("Fail t=%0t data_out exp %02h got %02h", $time, byte_q[0], data_out);
                end
                void'(byte_q.pop_front());
                void'(cyc_q.pop_front());
                void'(first_q.pop_front());
                byte_cnt++;
            end
            hit = 1'b0;
            if (pe_q.size() > 0) hit = (pe_q[0] == cyc);
            assert (mb_pre_end == hit) else begin
                err_cnt++;
                $display("Fail t=%0t mb_pre_end exp %0b got %0b", $time, hit, mb_pre_end);
            end
            if (hit) void'(pe_q.pop_front());
            hit = 1'b0;
            if (rel_q.size() > 0) hit = (rel_q[0] == cyc);
            assert (mb_release_buf == hit) else begin
                err_cnt++;
                $display("Fail t=%0t mb_release_buf exp %0b got %0b", $time, hit, mb_release_buf);
            end
            if (hit) begin
                void'(rel_q.pop_front());
                pulse_cnt++;
            end
        end
        prev_ack = mb_ack;
        prev_req = mb_req;
        prev_pe  = mb_pre_end;
        prev_pfo = pre_first_out;
    end

    initial begin
        int n;
        seed_val = $urandom(32'hd3ea);
        xclk = 1'b0;
        arst_n = 1'b0;
        frame_en = 1'b1;
        mb_req = 1'b0;
        start_page = '0;
        macroblock_x = '0;
        wr_en = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        converter_type = COLOR18;
        mb_w_m1 = '0;
        mb_h_m1 = '0;
        tile_width = '0;
        tile_col_width = 1'b0;
        step(3);                                 // reset over three rising edges
        arst_n = 1'b1;
        fill_buffer();
        for (int i = 0; i < 6; i++) begin
            apply_config(i);
            send_cmd(2'(case_tbl[i][5]), 7'(case_tbl[i][6]), 1'b0);
            send_cmd(2'(case_tbl[i][5] + 1), 7'(case_tbl[i][6]), 1'b1); // raised before pre_end
            wait_drain();
        end
        apply_config(0);                         // frame_en drop in the middle of a macroblock
        send_cmd(2'd0, 7'd8, 1'b0);
        n = 0;
        while (!data_valid) begin
            step(1);
            n++;
            if (n > wait_limit) abort_on_timeout("data_valid before frame_en drop");
        end
        step(10);
        frame_en = 1'b0;
        step(1);                                 // clear has taken effect
        quiet = 1'b1;
        byte_q.delete();
        cyc_q.delete();
        first_q.delete();
        pe_q.delete();
        rel_q.delete();
        step(20);
        frame_en = 1'b1;
        step(420);                               // past a full period, pacing must stay silent
        quiet = 1'b0;
        send_cmd(2'd1, 7'd8, 1'b0);
        send_cmd(2'd2, 7'd8, 1'b1);
        wait_drain();
        step(100);                               // catch late stray pulses
        finish_run();
    end

endmodule

//--- cmprs_pixel_top.sv
// pixel fetch front end only; the buffer write port must be filled before the matching command
module cmprs_pixel_top #(
    parameter int preend_early      = 6,
    parameter int release_early     = 16,
    parameter int buf_extra_latency = 0    // 0..2 tested
) (
    input  logic                             xclk,
    input  logic                             arst_n,
    input  logic                             frame_en,
    input  logic                             mb_req,
    input  logic [cmprs_pkg::page_w-1:0]     start_page,
    input  logic [6:0]                       macroblock_x,
    output logic                             mb_ack,
    input  logic                             wr_en,
    input  logic [cmprs_pkg::buf_addr_w-1:0] wr_addr,
    input  logic [7:0]                       wr_data,
    input  cmprs_pkg::cmprs_mode_e           converter_type,
    input  logic [5:0]                       mb_w_m1,
    input  logic [5:0]                       mb_h_m1,
    input  logic [1:0]                       tile_width,
    input  logic                             tile_col_width,
    output logic [7:0]                       data_out,
    output logic                             data_valid,
    output logic                             pre_first_out,
    output logic                             mb_release_buf
);
    import cmprs_pkg::*;

    logic                  mb_pre_start;   // sequencer -> interface
    logic                  mb_pre_end;     // interface -> sequencer
    logic [page_w-1:0]     seq_page;
    logic [6:0]            seq_x;
    logic [buf_addr_w-1:0] buf_ra;
    logic [1:0]            buf_rd;
    logic [7:0]            buf_di;

    cmprs_mb_sequencer u_seq (
        .xclk         (xclk),
        .arst_n       (arst_n),
        .frame_en     (frame_en),
        .mb_req       (mb_req),
        .start_page   (start_page),
        .macroblock_x (macroblock_x),
        .mb_pre_end   (mb_pre_end),
        .mb_ack       (mb_ack),
        .mb_pre_start (mb_pre_start),
        .seq_page     (seq_page),
        .seq_x        (seq_x)
    );

    cmprs_pixel_buf_iface #(
        .preend_early      (preend_early),
        .release_early     (release_early),
        .buf_extra_latency (buf_extra_latency)
    ) u_iface (
        .xclk           (xclk),
        .arst_n         (arst_n),
        .frame_en       (frame_en),
        .buf_di         (buf_di),
        .converter_type (converter_type),
        .mb_w_m1        (mb_w_m1),
        .mb_h_m1        (mb_h_m1),
        .tile_width     (tile_width),
        .tile_col_width (tile_col_width),
        .mb_pre_start   (mb_pre_start),
        .start_page     (seq_page),
        .macroblock_x   (seq_x),
        .buf_ra         (buf_ra),
        .buf_rd         (buf_rd),
        .mb_pre_end     (mb_pre_end),
        .mb_release_buf (mb_release_buf),
        .data_out       (data_out),
        .pre_first_out  (pre_first_out),
        .data_valid     (data_valid)
    );

    cmprs_tile_buf #(
        .buf_extra_latency (buf_extra_latency)
    ) u_buf (
        .xclk    (xclk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .buf_ra  (buf_ra),
        .buf_rd  (buf_rd),
        .buf_di  (buf_di)
    );

endmodule

//--- cmprs_mb_sequencer.sv
// four-phase req/ack intake; a command is only taken after mb_pre_end of the one in flight
module cmprs_mb_sequencer (
    input  logic                         xclk,
    input  logic                         arst_n,
    input  logic                         frame_en,     // low returns to IDLE at once
    input  logic                         mb_req,       // data must be stable while high
    input  logic [cmprs_pkg::page_w-1:0] start_page,
    input  logic [6:0]                   macroblock_x,
    input  logic                         mb_pre_end,   // pacing from the pixel interface
    output logic                         mb_ack,
    output logic                         mb_pre_start, // one cycle pulse after ack rises
    output logic [cmprs_pkg::page_w-1:0] seq_page,
    output logic [6:0]                   seq_x
);
    import cmprs_pkg::*;

    seq_state_e state;
    logic       end_pending;                            // current macroblock not paced out yet
    logic       end_seen;
    logic       accept;

    assign end_seen = mb_pre_end || !end_pending;
    // new request only after the previous four-phase cycle closed
    assign accept   = mb_req && !mb_ack &&
                      ((state == IDLE) || ((state == RUN) && end_seen));

    always_ff @(posedge xclk or negedge arst_n) begin
        if (!arst_n) begin
            state        <= IDLE;
            mb_ack       <= 1'b0;
            mb_pre_start <= 1'b0;
            end_pending  <= 1'b0;
        end else if (!frame_en) begin
            state        <= IDLE;
            mb_ack       <= 1'b0;
            mb_pre_start <= 1'b0;
            end_pending  <= 1'b0;
        end else begin
            mb_pre_start <= (state == START);            // ack already up this cycle

            if (accept) begin
                mb_ack <= 1'b1;
            end else if (!mb_req) begin
                mb_ack <= 1'b0;                          // phase 4
            end

            if (state == START) begin
                end_pending <= 1'b1;
            end else if (mb_pre_end) begin
                end_pending <= 1'b0;
            end

            case (state)
                IDLE: begin
                    if (accept) begin
                        state <= START;
                    end
                end
                START: begin
                    state <= RUN;
                end
                RUN: begin
                    if (accept) begin
                        state <= START;                  // back to back, no gap
                    end else if (end_seen && !mb_ack && !mb_req) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // command payload, captured on the ack edge
    always_ff @(posedge xclk) begin
        if (accept) begin
            seq_page <= start_page;
            seq_x    <= macroblock_x;
        end
    end

endmodule

//--- cmprs_pixel_buf_iface.sv
// configuration must stay static during a frame; each macroblock row must fit the page it starts in
module cmprs_pixel_buf_iface #(
    parameter int preend_early      = 6,   // mb_pre_end lead before the period ends
    parameter int release_early     = 16,  // page release lead before the period ends
    parameter int buf_extra_latency = 0    // register layers inside the buffer read path
) (
    input  logic                             xclk,
    input  logic                             arst_n,
    input  logic                             frame_en,       // low stops everything at once
    input  logic [7:0]                       buf_di,
    input  cmprs_pkg::cmprs_mode_e           converter_type,
    input  logic [5:0]                       mb_w_m1,        // macroblock width - 1
    input  logic [5:0]                       mb_h_m1,        // macroblock height - 1
    input  logic [1:0]                       tile_width,     // 16 << tile_width
    input  logic                             tile_col_width, // 0: 16, 1: 32
    input  logic                             mb_pre_start,   // one cycle before first address
    input  logic [cmprs_pkg::page_w-1:0]     start_page,
    input  logic [6:0]                       macroblock_x,   // left pixel, relative to start page
    output logic [cmprs_pkg::buf_addr_w-1:0] buf_ra,
    output logic [1:0]                       buf_rd,         // {regen, re}
    output logic                             mb_pre_end,
    output logic                             mb_release_buf,
    output logic [7:0]                       data_out,
    output logic                             pre_first_out,
    output logic                             data_valid
);
    import cmprs_pkg::*;

    localparam int off_w = buf_addr_w - page_w;          // offset inside a page
    localparam int dv_bit = buf_extra_latency + 3;       // data_valid tap of the re chain

    logic [dv_bit:0]              buf_re;                // re pipeline, bit 0 drives the buffer
    logic [dv_bit-1:0]            first_sr;              // first address marker pipeline
    logic [page_w-1:0]            page;                  // steps at each tile border
    logic [off_w-1:0]             buf_off;
    logic [buf_addr_w-1:0]        row_sa;                // current row start {page, offset}
    logic [off_w-1:0]             tile_sa;               // row start inside any later tile
    logic [off_w-1:0]             col_inc;               // jump to next tile column
    logic [5:0]                   cols_left;
    logic [5:0]                   rows_left;
    logic [6:0]                   tile_x;                // unused msbs held at one
    logic [4:0]                   column_x;              // unused msb held at one
    logic [8:0]                   period_cntr;
    logic [6:0]                   tile_or;
    logic [4:0]                   col_or;
    logic [1:0]                   tile_skip;             // whole tiles left of macroblock_x
    logic [page_w-1:0]            page0;
    logic [6:0]                   x_in_tile;
    logic [2:0]                   start_col;
    logic [4:0]                   x_in_col;
    logic [off_w-1:0]             col_w;
    logic [off_w-1:0]             col_stride;            // bytes per tile column
    logic [off_w-1:0]             start_off;
    logic [off_w-1:0]             next_row_off;
    logic                         row_end;
    logic                         run_end;

    assign tile_or      = 7'h70 << tile_width;           // 16:70 32:60 64:40 128:00
    assign col_or       = tile_col_width ? 5'h00 : 5'h10;
    assign col_w        = tile_col_width ? 10'd32 : 10'd16;
    assign col_stride   = ({4'd0, mb_h_m1} + 10'd1) << (tile_col_width ? 5 : 4);
    assign x_in_tile    = macroblock_x & ~tile_or;
    assign x_in_col     = macroblock_x[4:0] & ~col_or;
    assign start_col    = tile_col_width ? {1'b0, x_in_tile[6:5]} : x_in_tile[6:4];
    assign start_off    = {7'd0, start_col} * col_stride + {5'd0, x_in_col};
    assign page0        = start_page + tile_skip;        // wraps over 4 pages
    assign next_row_off = row_sa[off_w-1:0] + col_w;
    assign row_end      = (cols_left == 6'd0);
    assign run_end      = buf_re[0] && row_end && (rows_left == 6'd0);

    assign buf_ra        = {page, buf_off};
    assign buf_rd        = buf_re[1:0];
    assign data_valid    = buf_re[dv_bit];               // +3 after address incl. output reg
    assign pre_first_out = first_sr[dv_bit-1];           // one cycle ahead of data_valid

    always_comb begin
        case (tile_width)
            2'd0:    tile_skip = macroblock_x[5:4];
            2'd1:    tile_skip = macroblock_x[6:5];
            2'd2:    tile_skip = {1'b0, macroblock_x[6]};
            default: tile_skip = 2'd0;                   // 128 wide, never leaves the page
        endcase
    end

    // address walker, row by row, left to right
    always_ff @(posedge xclk) begin
        if (mb_pre_start) begin
            page      <= page0;
            buf_off   <= start_off;
            row_sa    <= {page0, start_off};
            tile_sa   <= '0;
            col_inc   <= col_stride - col_w + 10'd1;     // skip rest of the column height
            cols_left <= mb_w_m1;
            rows_left <= mb_h_m1;
            tile_x    <= macroblock_x | tile_or;
            column_x  <= macroblock_x[4:0] | col_or;
        end else if (buf_re[0]) begin
            if (row_end) begin
                page                <= row_sa[buf_addr_w-1:off_w]; // back to first tile
                buf_off             <= next_row_off;
                row_sa[off_w-1:0]   <= next_row_off;
                tile_sa             <= tile_sa + col_w;
                cols_left           <= mb_w_m1;
                rows_left           <= rows_left - 6'd1;
                tile_x              <= macroblock_x | tile_or;
                column_x            <= macroblock_x[4:0] | col_or;
            end else begin
                cols_left <= cols_left - 6'd1;
                tile_x    <= (tile_x + 7'd1) | tile_or;
                column_x  <= (column_x + 5'd1) | col_or;
                if (&tile_x) begin
                    page    <= page + 1'b1;              // next tile lives in next page
                    buf_off <= tile_sa;
                end else if (&column_x) begin
                    buf_off <= buf_off + col_inc;
                end else begin
                    buf_off <= buf_off + 10'd1;
                end
            end
        end
        if (buf_re[dv_bit-1]) begin
            data_out <= buf_di;                          // byte from the last buffer stage
        end
    end

    // read pipeline and pacing, frame_en acts as a synchronous clear
    always_ff @(posedge xclk or negedge arst_n) begin
        if (!arst_n) begin
            buf_re         <= '0;
            first_sr       <= '0;
            period_cntr    <= '0;
            mb_pre_end     <= 1'b0;
            mb_release_buf <= 1'b0;
        end else if (!frame_en) begin
            buf_re         <= '0;
            first_sr       <= '0;
            period_cntr    <= '0;
            mb_pre_end     <= 1'b0;
            mb_release_buf <= 1'b0;
        end else begin
            if (mb_pre_start) begin
                buf_re[0] <= 1'b1;
            end else if (run_end) begin
                buf_re[0] <= 1'b0;
            end
            buf_re[dv_bit:1] <= buf_re[dv_bit-1:0];
            first_sr         <= {first_sr[dv_bit-2:0], mb_pre_start};
            if (mb_pre_start) begin
                period_cntr <= mb_period(converter_type) - 9'd1;
            end else if (period_cntr != 9'd0) begin
                period_cntr <= period_cntr - 9'd1;
            end
            mb_pre_end     <= (period_cntr == 9'(preend_early + 2));  // P-early-1 after start
            mb_release_buf <= (period_cntr == 9'(release_early + 2));
        end
    end

endmodule

//--- cmprs_tile_buf.sv
// read data is valid buf_extra_latency+2 cycles after re; contents are undefined until written
module cmprs_tile_buf #(
    parameter int buf_extra_latency = 0             // extra register layers after the output reg
) (
    input  logic                            xclk,
    input  logic                            wr_en,   // write strobe from memory side
    input  logic [cmprs_pkg::buf_addr_w-1:0] wr_addr, // {page, offset}
    input  logic [7:0]                      wr_data,
    input  logic [cmprs_pkg::buf_addr_w-1:0] buf_ra,  // read address, 2 msb are the page
    input  logic [1:0]                      buf_rd,  // {regen, re}
    output logic [7:0]                      buf_di   // read data to the pixel interface
);
    import cmprs_pkg::*;

    logic [7:0] mem [0:(1 << buf_addr_w)-1];         // four 1 KiB pages
    logic [7:0] rd_q;                                // array read register
    logic [7:0] out_q;                               // output register

    always_ff @(posedge xclk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        if (buf_rd[0]) begin
            rd_q <= mem[buf_ra];                     // re stage
        end
        if (buf_rd[1]) begin
            out_q <= rd_q;                           // regen stage, one cycle after re
        end
    end

    // optional pipeline between the buffer and the consumer
    if (buf_extra_latency == 0) begin : g_direct
        assign buf_di = out_q;
    end else begin : g_extra
        logic [7:0] lat_q [0:buf_extra_latency-1];  // free running delay line

        always_ff @(posedge xclk) begin
            lat_q[0] <= out_q;
            for (int i = 1; i < buf_extra_latency; i++) begin
                lat_q[i] <= lat_q[i-1];
            end
        end

        assign buf_di = lat_q[buf_extra_latency-1];
    end

endmodule

//--- cmprs_pkg.sv
// shared types for the pixel fetch front end; mode codes 5 and 6 are unused and fall back to 384
package cmprs_pkg;

    localparam int buf_addr_w = 12; // 4 pages of 1 KiB
    localparam int page_w     = 2;  // page number field, top of buffer address

    // converter type, matches the compressor mode register
    typedef enum logic [2:0] {
        COLOR18 = 3'd0,             // 4:2:0 from 18x18 overlapping tiles
        COLOR20 = 3'd1,             // 20x20 padded tiles
        MONO16  = 3'd2,             // 16x16 mono, colour blocks zeroed later
        JP4     = 3'd3,             // jp4 16x16
        JP4DIFF = 3'd4,             // jp4 with differential blocks
        MONO8   = 3'd7              // plain mono 8x8
    } cmprs_mode_e;

    // macroblock sequencer states
    typedef enum logic [1:0] {
        IDLE  = 2'd0,               // nothing in flight
        START = 2'd1,               // command latched, ack up
        RUN   = 2'd2                // macroblock running, waiting for pre_end
    } seq_state_e;

    // cycles spent per macroblock by the slowest later stage
    function automatic logic [8:0] mb_period(input cmprs_mode_e mode);
        case (mode)
            COLOR18: return 9'd384; // 6 blocks of 64
            COLOR20: return 9'd400; // bound by the 20x20 padded read
            MONO16:  return 9'd384; // still 6 blocks, 2 of them empty
            JP4:     return 9'd256; // 4 blocks, exact
            JP4DIFF: return 9'd256;
            MONO8:   return 9'd64;  // single block
            default: return 9'd384;
        endcase
    endfunction

endpackage
